// ==== hw/fhe_vec_pkg.sv ====
package fhe_vec_pkg;

  localparam int FSIZE               = 16;
  localparam int LANES               = 4;
  localparam int VECTOR_SPLIT        = 2;
  localparam int BUFFER_READ_LATENCY = 2;
  localparam int MU_SIZE             = 17;  // floor(2^32/p)

  localparam int APB_AW    = 16;
  localparam int APB_DW    = 32;
  localparam int LANE_BITS = $clog2(LANES);
  localparam int ROW_BITS  = APB_AW - 2 - LANE_BITS;
  localparam int REG_BITS  = APB_AW - 1;

  localparam logic [3:0] OP_MULT        = 4'd1;
  localparam logic [3:0] OP_SCALAR_MULT = 4'd2;
  localparam logic [3:0] OP_ADD         = 4'd3;
  localparam logic [3:0] OP_SCALAR_ADD  = 4'd4;

  localparam logic [REG_BITS-1:0] REG_CTRL    = 'd0;  // op in [3:0], start in [8]
  localparam logic [REG_BITS-1:0] REG_STATUS  = 'd1;  // busy in [0], error in [1]
  localparam logic [REG_BITS-1:0] REG_MODULUS = 'd2;
  localparam logic [REG_BITS-1:0] REG_MU      = 'd3;
  localparam logic [REG_BITS-1:0] REG_SCALAR  = 'd4;

  typedef struct packed {
    logic                sel;  // low for registers
    logic [REG_BITS-1:0] idx;
  } reg_addr_t;

  typedef struct packed {
    logic                 sel;
    logic                 bank;  // 0 is operand 1
    logic [ROW_BITS-1:0]  row;
    logic [LANE_BITS-1:0] lane;
  } mem_addr_t;

  typedef union packed {
    reg_addr_t r;
    mem_addr_t m;
  } apb_addr_u;

endpackage

// ==== hw/delay_line.sv ====
`timescale 1ns/1ns

module delay_line #(
  parameter int DATA_SIZE = 1,
  parameter int DEPTH     = 1
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic [DATA_SIZE-1:0] in,
  output logic [DATA_SIZE-1:0] out
);

  logic [DEPTH-1:0][DATA_SIZE-1:0] stage;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      stage <= '0;
    end else begin
      stage[0] <= in;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign out = stage[DEPTH-1];

endmodule

// ==== hw/buffer_ram.sv ====
`timescale 1ns/1ns

module buffer_ram #(
  parameter int WIDTH = 4
) (
  input  logic                                                    clk,
  input  logic                                                    rstn,
  input  logic                                                    engine,
  input  logic [WIDTH-1:0]                                        eng_raddr,
  input  logic                                                    eng_wren,
  input  logic [WIDTH-1:0]                                        eng_waddr,
  input  logic [fhe_vec_pkg::LANES-1:0][fhe_vec_pkg::FSIZE-1:0]   eng_wdata,
  input  logic [WIDTH-1:0]                                        host_raddr,
  input  logic                                                    host_wren,
  input  logic [WIDTH-1:0]                                        host_waddr,
  input  logic [fhe_vec_pkg::LANE_BITS-1:0]                       host_lane,
  input  logic [fhe_vec_pkg::FSIZE-1:0]                           host_wdata,
  output logic [fhe_vec_pkg::LANES-1:0][fhe_vec_pkg::FSIZE-1:0]   rdata
);

  localparam int ROW_W = fhe_vec_pkg::LANES * fhe_vec_pkg::FSIZE;

  logic [fhe_vec_pkg::LANES-1:0][fhe_vec_pkg::FSIZE-1:0] mem [2**WIDTH];
  logic [WIDTH-1:0] raddr;
  logic [ROW_W-1:0] rd_word;

  assign raddr   = engine ? eng_raddr : host_raddr;
  assign rd_word = mem[raddr];

  always_ff @(posedge clk) begin
    if (eng_wren) begin
      mem[eng_waddr] <= eng_wdata;  // whole row
    end else if (host_wren) begin
      mem[host_waddr][host_lane] <= host_wdata;
    end
  end

  delay_line #(.DATA_SIZE(ROW_W), .DEPTH(fhe_vec_pkg::BUFFER_READ_LATENCY)) u_rd_pipe (
    .clk(clk), .rstn(rstn), .in(rd_word), .out(rdata)
  );

endmodule

// ==== hw/elem_mult.sv ====
`timescale 1ns/1ns

module elem_mult (
  input  logic                             clk,
  input  logic                             rstn,
  input  logic                             in_valid,
  input  logic                             in_last,
  input  logic [fhe_vec_pkg::FSIZE-1:0]    op1,
  input  logic [fhe_vec_pkg::FSIZE-1:0]    op2,
  input  logic [fhe_vec_pkg::FSIZE-1:0]    p,
  input  logic [fhe_vec_pkg::MU_SIZE-1:0]  mu,
  output logic [fhe_vec_pkg::FSIZE-1:0]    out,
  output logic                             out_valid,
  output logic                             out_last
);

  localparam int FS = fhe_vec_pkg::FSIZE;
  localparam int MS = fhe_vec_pkg::MU_SIZE;

  logic [2*FS-1:0] prod_s1;
  logic [2*FS-1:0] prod_s2;
  logic [FS+MS:0]  qm;
  logic [FS:0]     q_s2;
  logic [2*FS:0]   qp;
  logic [FS+1:0]   r0;
  logic [FS+1:0]   r1;
  logic [FS+1:0]   r2;
  logic [1:0]      ctl;

  assign qm = prod_s1[2*FS-1:FS-1] * mu;  // high bits times mu
  assign qp = q_s2 * p;
  assign r0 = prod_s2[FS+1:0] - qp[FS+1:0];  // below 3p
  assign r1 = (r0 >= p) ? r0 - p : r0;
  assign r2 = (r1 >= p) ? r1 - p : r1;

  always_ff @(posedge clk) begin
    prod_s1 <= op1 * op2;
    prod_s2 <= prod_s1;
    q_s2    <= qm[FS+MS:MS];
    out     <= r2[FS-1:0];
  end

  delay_line #(.DATA_SIZE(2), .DEPTH(3)) u_ctl (
    .clk(clk), .rstn(rstn), .in({in_valid, in_last}), .out(ctl)
  );

  assign out_valid = ctl[1];
  assign out_last  = ctl[0];

endmodule

// ==== hw/elem_add.sv ====
`timescale 1ns/1ns

module elem_add (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           in_valid,
  input  logic                           in_last,
  input  logic [fhe_vec_pkg::FSIZE-1:0]  op1,
  input  logic [fhe_vec_pkg::FSIZE-1:0]  op2,
  input  logic [fhe_vec_pkg::FSIZE-1:0]  p,
  output logic [fhe_vec_pkg::FSIZE-1:0]  out,
  output logic                           out_valid,
  output logic                           out_last
);

  localparam int FS = fhe_vec_pkg::FSIZE;

  logic [FS:0] sum_s1;  // keeps the carry
  logic [FS:0] diff;
  logic [1:0]  ctl;

  assign diff = sum_s1 - p;

  always_ff @(posedge clk) begin
    sum_s1 <= op1 + op2;
    out    <= (sum_s1 >= p) ? diff[FS-1:0] : sum_s1[FS-1:0];
  end

  delay_line #(.DATA_SIZE(2), .DEPTH(2)) u_ctl (
    .clk(clk), .rstn(rstn), .in({in_valid, in_last}), .out(ctl)
  );

  assign out_valid = ctl[1];
  assign out_last  = ctl[0];

endmodule

// ==== hw/vector_control.sv ====
`timescale 1ns/1ns

module vector_control #(
  parameter int WIDTH = 4
) (
  input  logic                                                   clk,
  input  logic                                                   rstn,
  input  logic                                                   start,
  input  logic [3:0]                                             operation,
  input  logic [fhe_vec_pkg::FSIZE-1:0]                          p,
  input  logic [fhe_vec_pkg::MU_SIZE-1:0]                        mu,
  input  logic [fhe_vec_pkg::FSIZE-1:0]                          scalar,
  input  logic [fhe_vec_pkg::LANES-1:0][fhe_vec_pkg::FSIZE-1:0]  rdata1,
  input  logic [fhe_vec_pkg::LANES-1:0][fhe_vec_pkg::FSIZE-1:0]  rdata2,
  output logic [WIDTH-1:0]                                       raddr,
  output logic                                                   wren,
  output logic [WIDTH-1:0]                                       waddr,
  output logic [fhe_vec_pkg::LANES-1:0][fhe_vec_pkg::FSIZE-1:0]  wdata,
  output logic                                                   working,
  output logic                                                   done,
  output logic                                                   bad_op
);

  localparam int FS   = fhe_vec_pkg::FSIZE;
  localparam int HALF = fhe_vec_pkg::LANES / fhe_vec_pkg::VECTOR_SPLIT;
  localparam int SB   = $clog2(fhe_vec_pkg::VECTOR_SPLIT);
  localparam int LAT  = fhe_vec_pkg::BUFFER_READ_LATENCY;

  logic                 loading;
  logic                 draining;
  logic [WIDTH+SB-1:0]  load_idx;
  logic [WIDTH+SB-1:0]  store_idx;
  logic                 is_mult;
  logic                 is_add;
  logic                 is_scalar;
  logic                 mult_in_valid;
  logic                 add_in_valid;
  logic [SB:0]          rd_ctl;
  logic                 rd_last;
  logic [SB-1:0]        rd_split;
  logic                 unit_last;
  logic [HALF-1:0][FS-1:0] a1;
  logic [HALF-1:0][FS-1:0] a2;
  logic [HALF-1:0][FS-1:0] b_op;
  logic [HALF-1:0][FS-1:0] mult_res;
  logic [HALF-1:0][FS-1:0] add_res;
  logic [HALF-1:0][FS-1:0] res;
  logic [HALF-1:0]      mult_vld;
  logic [HALF-1:0]      mult_lst;
  logic [HALF-1:0]      add_vld;
  logic [HALF-1:0]      add_lst;
  logic                 res_valid;
  logic                 res_last;

  assign is_mult   = (operation == fhe_vec_pkg::OP_MULT) ||
                     (operation == fhe_vec_pkg::OP_SCALAR_MULT);
  assign is_add    = (operation == fhe_vec_pkg::OP_ADD) ||
                     (operation == fhe_vec_pkg::OP_SCALAR_ADD);
  assign is_scalar = (operation == fhe_vec_pkg::OP_SCALAR_MULT) ||
                     (operation == fhe_vec_pkg::OP_SCALAR_ADD);

  assign working = loading | draining;
  assign raddr   = load_idx[WIDTH+SB-1:SB];

  // valids skip the capture register, so one cycle longer
  delay_line #(.DATA_SIZE(1), .DEPTH(LAT+1)) u_mult_vld (
    .clk(clk), .rstn(rstn), .in(loading & is_mult), .out(mult_in_valid)
  );

  delay_line #(.DATA_SIZE(1), .DEPTH(LAT+1)) u_add_vld (
    .clk(clk), .rstn(rstn), .in(loading & is_add), .out(add_in_valid)
  );

  delay_line #(.DATA_SIZE(SB+1), .DEPTH(LAT)) u_rd_ctl (
    .clk(clk), .rstn(rstn), .in({loading & (&load_idx), load_idx[SB-1:0]}), .out(rd_ctl)
  );

  assign rd_last  = rd_ctl[SB];
  assign rd_split = rd_ctl[SB-1:0];

  for (genvar i = 0; i < HALF; i++) begin : g_unit
    assign b_op[i] = is_scalar ? scalar : a2[i];

    elem_mult u_mult (
      .clk(clk), .rstn(rstn), .in_valid(mult_in_valid), .in_last(unit_last),
      .op1(a1[i]), .op2(b_op[i]), .p(p), .mu(mu),
      .out(mult_res[i]), .out_valid(mult_vld[i]), .out_last(mult_lst[i])
    );

    elem_add u_add (
      .clk(clk), .rstn(rstn), .in_valid(add_in_valid), .in_last(unit_last),
      .op1(a1[i]), .op2(b_op[i]), .p(p),
      .out(add_res[i]), .out_valid(add_vld[i]), .out_last(add_lst[i])
    );
  end

  assign res_valid = is_mult ? &mult_vld : &add_vld;
  assign res_last  = is_mult ? &mult_lst : &add_lst;
  assign res       = is_mult ? mult_res : add_res;

  always_ff @(posedge clk) begin
    for (int i = 0; i < HALF; i++) begin
      a1[i] <= rdata1[rd_split*HALF+i];  // half picked by split id
      a2[i] <= rdata2[rd_split*HALF+i];
    end
    if (res_valid) begin
      waddr <= store_idx[WIDTH+SB-1:SB];
      for (int i = 0; i < HALF; i++) begin
        wdata[store_idx[SB-1:0]*HALF+i] <= res[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      loading   <= 1'b0;
      draining  <= 1'b0;
      load_idx  <= '0;
      store_idx <= '0;
      unit_last <= 1'b0;
      wren      <= 1'b0;
      done      <= 1'b0;
      bad_op    <= 1'b0;
    end else begin
      wren      <= 1'b0;
      done      <= 1'b0;
      bad_op    <= 1'b0;
      unit_last <= rd_last;
      if (start && !working) begin
        if (is_mult || is_add) begin
          loading   <= 1'b1;
          load_idx  <= '0;
          store_idx <= '0;
        end else begin
          bad_op <= 1'b1;  // no run
        end
      end
      if (loading) begin
        load_idx <= load_idx + 1'b1;
        if (&load_idx) begin
          loading  <= 1'b0;
          draining <= 1'b1;
        end
      end
      if (res_valid) begin
        store_idx <= store_idx + 1'b1;
        if (store_idx[SB-1:0] == SB'(fhe_vec_pkg::VECTOR_SPLIT - 1)) begin
          wren <= 1'b1;  // row complete
        end
        if (res_last) begin
          draining <= 1'b0;
          done     <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== hw/apb_regs.sv ====
`timescale 1ns/1ns

module apb_regs #(
  parameter int WIDTH = 4
) (
  input  logic                                                   clk,
  input  logic                                                   rstn,
  input  logic                                                   psel,
  input  logic                                                   penable,
  input  logic                                                   pwrite,
  input  logic [fhe_vec_pkg::APB_AW-1:0]                         paddr,
  input  logic [fhe_vec_pkg::APB_DW-1:0]                         pwdata,
  output logic [fhe_vec_pkg::APB_DW-1:0]                         prdata,
  output logic                                                   pready,
  output logic                                                   pslverr,
  input  logic                                                   working,
  input  logic                                                   done_in,
  input  logic                                                   bad_op,
  output logic                                                   start,
  output logic [3:0]                                             operation,
  output logic [fhe_vec_pkg::FSIZE-1:0]                          p,
  output logic [fhe_vec_pkg::MU_SIZE-1:0]                        mu,
  output logic [fhe_vec_pkg::FSIZE-1:0]                          scalar,
  output logic [WIDTH-1:0]                                       host_raddr,
  output logic [1:0]                                             host_wren,
  output logic [WIDTH-1:0]                                       host_waddr,
  output logic [fhe_vec_pkg::LANE_BITS-1:0]                      host_lane,
  output logic [fhe_vec_pkg::FSIZE-1:0]                          host_wdata,
  input  logic [fhe_vec_pkg::LANES-1:0][fhe_vec_pkg::FSIZE-1:0]  rdata1,
  input  logic [fhe_vec_pkg::LANES-1:0][fhe_vec_pkg::FSIZE-1:0]  rdata2
);

  localparam int FS  = fhe_vec_pkg::FSIZE;
  localparam int LAT = fhe_vec_pkg::BUFFER_READ_LATENCY;
  localparam int CW  = $clog2(LAT + 1);

  fhe_vec_pkg::apb_addr_u addr;
  logic          access;
  logic          busy;
  logic          is_mem;
  logic          reg_wr;
  logic          mem_wr;
  logic          err;
  logic [CW-1:0] wait_cnt;

  assign addr   = paddr;
  assign access = psel & penable;
  assign busy   = working | start;  // start cycle counts as busy
  assign is_mem = addr.m.sel;
  assign reg_wr = access & pwrite & ~is_mem & ~busy;
  assign mem_wr = access & pwrite & is_mem & ~busy;

  assign host_raddr   = addr.m.row[WIDTH-1:0];
  assign host_waddr   = addr.m.row[WIDTH-1:0];
  assign host_lane    = addr.m.lane;
  assign host_wdata   = pwdata[FS-1:0];
  assign host_wren[0] = mem_wr & ~addr.m.bank;
  assign host_wren[1] = mem_wr & addr.m.bank;

  assign pready  = access & (~is_mem | pwrite | busy | (wait_cnt == CW'(LAT)));
  assign pslverr = access & is_mem & busy;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wait_cnt <= '0;
    end else if (access && is_mem && !pwrite && !busy && !pready) begin
      wait_cnt <= wait_cnt + 1'b1;  // buffer read latency
    end else begin
      wait_cnt <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      start     <= 1'b0;
      operation <= '0;
      p         <= '0;
      mu        <= '0;
      scalar    <= '0;
      err       <= 1'b0;
    end else begin
      start <= reg_wr & (addr.r.idx == fhe_vec_pkg::REG_CTRL) & pwdata[8];
      if (bad_op) begin
        err <= 1'b1;
      end else if (done_in) begin
        err <= 1'b0;  // cleared by the next completed run
      end
      if (reg_wr) begin
        case (addr.r.idx)
          fhe_vec_pkg::REG_CTRL:    operation <= pwdata[3:0];
          fhe_vec_pkg::REG_MODULUS: p         <= pwdata[FS-1:0];
          fhe_vec_pkg::REG_MU:      mu        <= pwdata[fhe_vec_pkg::MU_SIZE-1:0];
          fhe_vec_pkg::REG_SCALAR:  scalar    <= pwdata[FS-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (is_mem) begin
      prdata[FS-1:0] = addr.m.bank ? rdata2[addr.m.lane] : rdata1[addr.m.lane];
    end else begin
      case (addr.r.idx)
        fhe_vec_pkg::REG_CTRL:    prdata[3:0]  = operation;
        fhe_vec_pkg::REG_STATUS:  prdata[1:0]  = {err, busy};
        fhe_vec_pkg::REG_MODULUS: prdata[FS-1:0] = p;
        fhe_vec_pkg::REG_MU:      prdata[fhe_vec_pkg::MU_SIZE-1:0] = mu;
        fhe_vec_pkg::REG_SCALAR:  prdata[FS-1:0] = scalar;
        default: ;
      endcase
    end
  end

endmodule

// ==== hw/fhe_vec_top.sv ====
`timescale 1ns/1ns

module fhe_vec_top #(
  parameter int WIDTH = 4
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [fhe_vec_pkg::APB_AW-1:0] paddr,
  input  logic [fhe_vec_pkg::APB_DW-1:0] pwdata,
  output logic [fhe_vec_pkg::APB_DW-1:0] prdata,
  output logic                           pready,
  output logic                           pslverr,
  output logic                           done
);

  localparam int FS = fhe_vec_pkg::FSIZE;
  localparam int LN = fhe_vec_pkg::LANES;

  logic                 start;
  logic [3:0]           operation;
  logic [FS-1:0]        p;
  logic [fhe_vec_pkg::MU_SIZE-1:0] mu;
  logic [FS-1:0]        scalar;
  logic                 working;
  logic                 bad_op;
  logic [WIDTH-1:0]     host_raddr;
  logic [1:0]           host_wren;
  logic [WIDTH-1:0]     host_waddr;
  logic [fhe_vec_pkg::LANE_BITS-1:0] host_lane;
  logic [FS-1:0]        host_wdata;
  logic [LN-1:0][FS-1:0] rdata1;
  logic [LN-1:0][FS-1:0] rdata2;
  logic [WIDTH-1:0]     eng_raddr;
  logic                 eng_wren;
  logic [WIDTH-1:0]     eng_waddr;
  logic [LN-1:0][FS-1:0] eng_wdata;

  apb_regs #(.WIDTH(WIDTH)) u_regs (
    .clk(clk), .rstn(rstn), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .working(working), .done_in(done), .bad_op(bad_op),
    .start(start), .operation(operation), .p(p), .mu(mu), .scalar(scalar),
    .host_raddr(host_raddr), .host_wren(host_wren), .host_waddr(host_waddr),
    .host_lane(host_lane), .host_wdata(host_wdata), .rdata1(rdata1), .rdata2(rdata2)
  );

  // operand 1 also takes the results
  buffer_ram #(.WIDTH(WIDTH)) u_buf1 (
    .clk(clk), .rstn(rstn), .engine(working),
    .eng_raddr(eng_raddr), .eng_wren(eng_wren), .eng_waddr(eng_waddr), .eng_wdata(eng_wdata),
    .host_raddr(host_raddr), .host_wren(host_wren[0]), .host_waddr(host_waddr),
    .host_lane(host_lane), .host_wdata(host_wdata), .rdata(rdata1)
  );

  buffer_ram #(.WIDTH(WIDTH)) u_buf2 (
    .clk(clk), .rstn(rstn), .engine(working),
    .eng_raddr(eng_raddr), .eng_wren(1'b0), .eng_waddr('0), .eng_wdata('0),
    .host_raddr(host_raddr), .host_wren(host_wren[1]), .host_waddr(host_waddr),
    .host_lane(host_lane), .host_wdata(host_wdata), .rdata(rdata2)
  );

  vector_control #(.WIDTH(WIDTH)) u_ctrl (
    .clk(clk), .rstn(rstn), .start(start), .operation(operation),
    .p(p), .mu(mu), .scalar(scalar), .rdata1(rdata1), .rdata2(rdata2),
    .raddr(eng_raddr), .wren(eng_wren), .waddr(eng_waddr), .wdata(eng_wdata),
    .working(working), .done(done), .bad_op(bad_op)
  );

endmodule

// ==== tests/tb_fhe_vec.sv ====
`timescale 1ns/1ns

module tb_fhe_vec;

  localparam int WIDTH  = 4;
  localparam int ROWS   = 2**WIDTH;
  localparam int LANES  = fhe_vec_pkg::LANES;
  localparam int FS     = fhe_vec_pkg::FSIZE;
  localparam int PERIOD = 20;
  localparam int NTESTS = 7;
  localparam int LIMIT  = NTESTS * ROWS * LANES * 10 + 2000;

  logic        clk;
  logic        rstn;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        done;

  logic [FS-1:0] mem1 [ROWS][LANES];  // expected buffer contents
  logic [FS-1:0] mem2 [ROWS][LANES];
  logic [FS-1:0] cur_p;
  logic [FS-1:0] cur_scalar;
  logic [31:0]   rd_val;
  logic          rd_err;
  integer        seed = 32'h44c8;
  int errors = 0;
  int checks = 0;
  int failed_tests = 0;
  int test_errs = 0;
  int done_cnt = 0;
  int done_before = 0;
  int busy_cycles = 0;
  int busy_before = 0;

  fhe_vec_top #(.WIDTH(WIDTH)) dut (
    .clk(clk), .rstn(rstn), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (done) done_cnt <= done_cnt + 1;
    if (dut.working) busy_cycles <= busy_cycles + 1;
  end

  initial begin
    repeat (LIMIT) @(posedge clk);
    $display("watchdog: simulation did not finish within %0d cycles", LIMIT);
    $display("Test failed");
    $finish;
  end

  function automatic logic [FS-1:0] expected_lane(input logic [FS-1:0] a, input logic [FS-1:0] b,
                                                  input logic [FS-1:0] s, input logic [FS-1:0] m,
                                                  input logic [3:0] op);
    longint unsigned x;
    longint unsigned y;
    x = a;
    y = b;
    if (op == fhe_vec_pkg::OP_SCALAR_MULT || op == fhe_vec_pkg::OP_SCALAR_ADD) y = s;
    case (op)
      fhe_vec_pkg::OP_MULT, fhe_vec_pkg::OP_SCALAR_MULT: return FS'((x * y) % m);
      fhe_vec_pkg::OP_ADD, fhe_vec_pkg::OP_SCALAR_ADD:   return FS'((x + y) % m);
      default: return a;  // no run, buffer untouched
    endcase
  endfunction

  function automatic logic [15:0] reg_addr(input logic [fhe_vec_pkg::REG_BITS-1:0] idx);
    fhe_vec_pkg::apb_addr_u a;
    a = '0;
    a.r.idx = idx;
    return a;
  endfunction

  function automatic logic [15:0] mem_addr(input logic bank, input int row, input int lane);
    fhe_vec_pkg::apb_addr_u a;
    a = '0;
    a.m.sel  = 1'b1;
    a.m.bank = bank;
    a.m.row  = row[fhe_vec_pkg::ROW_BITS-1:0];
    a.m.lane = lane[fhe_vec_pkg::LANE_BITS-1:0];
    return a;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // called at a falling edge, returns at one
  task automatic wait_ready(output logic [31:0] data, output logic err);
    @(negedge clk);
    penable = 1'b1;
    #(PERIOD/4);
    while (!pready) begin
      @(negedge clk);
      #(PERIOD/4);
    end
    data = prdata;
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [15:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    wait_ready(unused, err);
  endtask

  task automatic apb_read(input logic [15:0] addr, output logic [31:0] data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    wait_ready(data, err);
  endtask

  task automatic set_modulus(input logic [FS-1:0] m);
    logic [31:0] mu;
    logic        err;
    cur_p = m;
    mu = 32'((64'd1 << 32) / m);  // floor(2^32/p)
    apb_write(reg_addr(fhe_vec_pkg::REG_MODULUS), {16'd0, m}, err);
    apb_write(reg_addr(fhe_vec_pkg::REG_MU), mu, err);
    apb_read(reg_addr(fhe_vec_pkg::REG_MODULUS), rd_val, err);
    check("modulus", rd_val, {16'd0, m});
    apb_read(reg_addr(fhe_vec_pkg::REG_MU), rd_val, err);
    check("mu", rd_val, mu);
  endtask

  task automatic set_scalar();
    logic err;
    cur_scalar = FS'($unsigned($random(seed)) % cur_p);
    apb_write(reg_addr(fhe_vec_pkg::REG_SCALAR), {16'd0, cur_scalar}, err);
    apb_read(reg_addr(fhe_vec_pkg::REG_SCALAR), rd_val, err);
    check("scalar", rd_val, {16'd0, cur_scalar});
  endtask

  task automatic load_operands(input bit edge_row);
    logic err;
    for (int r = 0; r < ROWS; r++) begin
      for (int l = 0; l < LANES; l++) begin
        mem1[r][l] = FS'($unsigned($random(seed)) % cur_p);
        mem2[r][l] = FS'($unsigned($random(seed)) % cur_p);
        if (edge_row && r == 0) begin
          mem1[r][l] = cur_p - 1'b1;  // largest residues
          mem2[r][l] = cur_p - 1'b1;
        end
        apb_write(mem_addr(1'b0, r, l), {16'd0, mem1[r][l]}, err);
        apb_write(mem_addr(1'b1, r, l), {16'd0, mem2[r][l]}, err);
      end
    end
  endtask

  task automatic start_op(input logic [3:0] op);
    logic err;
    done_before = done_cnt;
    busy_before = busy_cycles;
    apb_write(reg_addr(fhe_vec_pkg::REG_CTRL), {23'd0, 1'b1, 4'd0, op}, err);
  endtask

  task automatic finish_run(input logic [3:0] op);
    while (done_cnt == done_before) @(negedge clk);
    repeat (3) @(negedge clk);
    check("done pulses", done_cnt, done_before + 1);
    apb_read(reg_addr(fhe_vec_pkg::REG_STATUS), rd_val, rd_err);
    check("status", rd_val, 32'd0);
    for (int r = 0; r < ROWS; r++) begin
      for (int l = 0; l < LANES; l++) begin
        mem1[r][l] = expected_lane(mem1[r][l], mem2[r][l], cur_scalar, cur_p, op);
      end
    end
  endtask

  task automatic verify_buffers(input bit with_bank2);
    for (int r = 0; r < ROWS; r++) begin
      for (int l = 0; l < LANES; l++) begin
        apb_read(mem_addr(1'b0, r, l), rd_val, rd_err);
        check($sformatf("buf1[%0d][%0d]", r, l), rd_val, {16'd0, mem1[r][l]});
        if (with_bank2) begin
          apb_read(mem_addr(1'b1, r, l), rd_val, rd_err);
          check($sformatf("buf2[%0d][%0d]", r, l), rd_val, {16'd0, mem2[r][l]});
        end
      end
    end
  endtask

  task automatic end_test(input string name);
    if (errors == test_errs) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors - test_errs);
    end
    test_errs = errors;
  endtask

  initial begin
    rstn    = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    cur_p      = 16'd1;
    cur_scalar = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    check("pready", pready, 32'd0);
    check("pslverr", pslverr, 32'd0);
    apb_read(reg_addr(fhe_vec_pkg::REG_STATUS), rd_val, rd_err);
    check("status", rd_val, 32'd0);
    set_modulus(16'd40961);
    set_scalar();
    end_test("register_access");

    load_operands(1'b1);
    start_op(fhe_vec_pkg::OP_MULT);
    finish_run(fhe_vec_pkg::OP_MULT);
    verify_buffers(1'b0);
    end_test("elementwise_mult");

    set_scalar();
    load_operands(1'b0);
    start_op(fhe_vec_pkg::OP_SCALAR_MULT);
    finish_run(fhe_vec_pkg::OP_SCALAR_MULT);
    verify_buffers(1'b0);
    end_test("scalar_mult");

    set_modulus(16'd65521);
    load_operands(1'b1);
    start_op(fhe_vec_pkg::OP_ADD);
    finish_run(fhe_vec_pkg::OP_ADD);
    verify_buffers(1'b0);
    end_test("elementwise_add");

    set_scalar();
    load_operands(1'b0);
    start_op(fhe_vec_pkg::OP_SCALAR_ADD);
    finish_run(fhe_vec_pkg::OP_SCALAR_ADD);
    verify_buffers(1'b0);
    end_test("scalar_add");

    load_operands(1'b0);
    start_op(fhe_vec_pkg::OP_ADD);
    apb_write(mem_addr(1'b1, 3, 1), 32'h1234, rd_err);  // must be rejected
    check("pslverr", rd_err, 32'd1);
    apb_read(mem_addr(1'b0, 0, 0), rd_val, rd_err);
    check("pslverr", rd_err, 32'd1);
    apb_read(reg_addr(fhe_vec_pkg::REG_STATUS), rd_val, rd_err);
    check("status", rd_val, 32'd1);  // run still in progress
    finish_run(fhe_vec_pkg::OP_ADD);
    verify_buffers(1'b1);
    end_test("access_while_busy");

    start_op(4'hf);
    repeat (4) @(negedge clk);
    apb_read(reg_addr(fhe_vec_pkg::REG_STATUS), rd_val, rd_err);
    check("status", rd_val, 32'd2);
    check("working cycles", busy_cycles, busy_before);
    check("done pulses", done_cnt, done_before);
    verify_buffers(1'b1);
    end_test("invalid_op");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             NTESTS, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
hw/fhe_vec_pkg.sv
hw/delay_line.sv
hw/buffer_ram.sv
hw/elem_mult.sv
hw/elem_add.sv
hw/vector_control.sv
hw/apb_regs.sv
hw/fhe_vec_top.sv
tests/tb_fhe_vec.sv

// ==== Bender.yml ====
package:
  name: fhe_vec

sources:
  - hw/fhe_vec_pkg.sv
  - hw/delay_line.sv
  - hw/buffer_ram.sv
  - hw/elem_mult.sv
  - hw/elem_add.sv
  - hw/vector_control.sv
  - hw/apb_regs.sv
  - hw/fhe_vec_top.sv
  - target: test
    files:
      - tests/tb_fhe_vec.sv
